// File: common_pkg.sv
`default_nettype none

package common_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic              bool;

    // first fetch goes here
    localparam addr_t PCINIT = 32'h8000_0000;

    // instruction rom geometry, word indexed
    localparam int ROM_AW    = 8;
    localparam int ROM_WORDS = 1 << ROM_AW;

    // control opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        bool   valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        bool   addr_ok;
        bool   data_ok;
        word_t data;
    } ibus_resp_t;

endpackage

`default_nettype wire

// File: temp_storage_pkg.sv
`default_nettype none

package temp_storage_pkg;

    // fetch to decode
    typedef struct packed {
        common_pkg::bool   valid;
        common_pkg::word_t inst;
        common_pkg::addr_t inst_pc;
        common_pkg::word_t inst_counter;
    } if_id_t;

    // jump unit back to fetch
    typedef struct packed {
        common_pkg::bool   jump_inst;
        common_pkg::bool   do_jump;
        common_pkg::addr_t dest_addr;
        common_pkg::word_t inst_counter;
    } jump_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // used for jalr
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        common_pkg::word_t raw;
        b_type_t           b;
        j_type_t           j;
        i_type_t           i;
    } inst_t;

endpackage

`default_nettype wire

// File: ibus_if.sv
`default_nettype none

interface ibus_if;

    // request held by fetch until addr_ok and data_ok
    common_pkg::ibus_req_t  req;
    common_pkg::ibus_resp_t resp;

    modport fetch_mp (
        output req,
        input  resp
    );

    modport rom_mp (
        input  req,
        output resp
    );

endinterface

`default_nettype wire

// File: jump_if.sv
`default_nettype none

interface jump_if;

    // level, held until the next accepted instruction
    temp_storage_pkg::jump_t report;

    modport unit_mp (
        output report
    );

    modport fetch_mp (
        input report
    );

endinterface

`default_nettype wire

// File: fetch.sv
`default_nettype none

module fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  common_pkg::bool          enable,
    ibus_if.fetch_mp                 ibus,
    jump_if.fetch_mp                 jump,
    output common_pkg::addr_t        pc,
    output temp_storage_pkg::if_id_t if_id_state,
    output common_pkg::bool          ok
);

    common_pkg::ibus_req_t req_q;
    common_pkg::addr_t     last_pc;
    common_pkg::bool       waiting;
    common_pkg::bool       stall;
    common_pkg::word_t     stall_tag;
    common_pkg::word_t     inst_counter;

    common_pkg::bool   resp_done;
    common_pkg::bool   resume;
    common_pkg::bool   take_jump;
    common_pkg::bool   is_ctrl;
    common_pkg::addr_t next_addr;
    common_pkg::word_t next_count;
    logic [6:0]        resp_opcode;

    assign resp_done = ibus.resp.addr_ok & ibus.resp.data_ok;

    // a stale report from an older jump never matches the tag
    assign resume = !stall
        || (jump.report.jump_inst && jump.report.inst_counter == stall_tag);
    assign take_jump = stall && jump.report.jump_inst && jump.report.do_jump;
    assign next_addr = take_jump ? jump.report.dest_addr : pc + 32'd4;

    assign next_count  = inst_counter + 32'd1;
    assign resp_opcode = ibus.resp.data[6:0];
    assign is_ctrl = (resp_opcode == common_pkg::OP_BRANCH)
        || (resp_opcode == common_pkg::OP_JAL)
        || (resp_opcode == common_pkg::OP_JALR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc           <= common_pkg::PCINIT - 32'd4;
            last_pc      <= common_pkg::PCINIT - 32'd4;
            waiting      <= 1'b0;
            stall        <= 1'b0;
            stall_tag    <= '0;
            inst_counter <= '0;
            req_q.valid  <= 1'b0;
            req_q.addr   <= '0;
            // bubble record, skipped downstream
            if_id_state.valid        <= 1'b1;
            if_id_state.inst         <= '0;
            if_id_state.inst_pc      <= common_pkg::PCINIT;
            if_id_state.inst_counter <= '0;
        end else begin
            // valid is a one cycle strobe
            if_id_state.valid <= 1'b0;

            if (waiting) begin
                if (resp_done) begin
                    waiting      <= 1'b0;
                    req_q.valid  <= 1'b0;
                    inst_counter <= next_count;

                    if_id_state.valid        <= 1'b1;
                    if_id_state.inst         <= ibus.resp.data;
                    if_id_state.inst_pc      <= last_pc;
                    if_id_state.inst_counter <= next_count;

                    // hold off until the jump unit resolves it
                    stall     <= is_ctrl;
                    stall_tag <= next_count;
                end
            end else if (enable && resume) begin
                stall       <= 1'b0;
                waiting     <= 1'b1;
                req_q.valid <= 1'b1;
                req_q.addr  <= next_addr;
                last_pc     <= next_addr;
                pc          <= next_addr;
            end
        end
    end

    assign ibus.req = req_q;
    assign ok       = !waiting;

endmodule

`default_nettype wire

// File: inst_rom.sv
`default_nettype none

module inst_rom (
    input logic    clk,
    input logic    rst,
    ibus_if.rom_mp ibus
);

    common_pkg::word_t mem [common_pkg::ROM_WORDS];

    logic [1:0]        wait_cnt;
    logic [1:0]        wait_next;
    logic [1:0]        pat_idx;
    logic [1:0]        latency;
    common_pkg::bool   resp_ok;
    common_pkg::word_t resp_data;

    initial begin
        $readmemh("program.hex", mem);
    end

    // latency pattern 1, 3, 2
    always_comb begin
        case (pat_idx)
            2'd0:    latency = 2'd1;
            2'd1:    latency = 2'd3;
            default: latency = 2'd2;
        endcase
    end

    assign wait_next = wait_cnt + 2'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            pat_idx  <= '0;
            resp_ok  <= 1'b0;
        end else if (resp_ok) begin
            // transfer done this cycle
            resp_ok  <= 1'b0;
            wait_cnt <= '0;
            pat_idx  <= (pat_idx == 2'd2) ? 2'd0 : pat_idx + 2'd1;
        end else if (ibus.req.valid) begin
            wait_cnt <= wait_next;
            resp_ok  <= (wait_next == latency);
        end
    end

    always_ff @(posedge clk) begin
        resp_data <= mem[ibus.req.addr[common_pkg::ROM_AW+1:2]];
    end

    assign ibus.resp.addr_ok = resp_ok;
    assign ibus.resp.data_ok = resp_ok;
    assign ibus.resp.data    = resp_data;

endmodule

`default_nettype wire

// File: jump_unit.sv
`default_nettype none

module jump_unit (
    input logic                     clk,
    input logic                     rst,
    input temp_storage_pkg::if_id_t if_id_state,
    input common_pkg::word_t        rs1_data,
    input common_pkg::word_t        rs2_data,
    jump_if.unit_mp                 jump
);

    temp_storage_pkg::inst_t inst;

    common_pkg::addr_t b_imm;
    common_pkg::addr_t j_imm;
    common_pkg::addr_t i_imm;
    common_pkg::addr_t target;
    common_pkg::bool   is_branch;
    common_pkg::bool   is_jal;
    common_pkg::bool   is_jalr;
    common_pkg::bool   br_taken;

    common_pkg::bool   jump_inst_q;
    common_pkg::bool   do_jump_q;
    common_pkg::addr_t dest_q;
    common_pkg::word_t tag_q;

    assign inst = if_id_state.inst;

    assign is_branch = inst.b.opcode == common_pkg::OP_BRANCH;
    assign is_jal    = inst.j.opcode == common_pkg::OP_JAL;
    assign is_jalr   = inst.i.opcode == common_pkg::OP_JALR;

    assign b_imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign j_imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    assign i_imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};

    always_comb begin
        case (inst.b.funct3)
            common_pkg::F3_BEQ:  br_taken = rs1_data == rs2_data;
            common_pkg::F3_BNE:  br_taken = rs1_data != rs2_data;
            common_pkg::F3_BLT:  br_taken = $signed(rs1_data) < $signed(rs2_data);
            common_pkg::F3_BGE:  br_taken = $signed(rs1_data) >= $signed(rs2_data);
            common_pkg::F3_BLTU: br_taken = rs1_data < rs2_data;
            common_pkg::F3_BGEU: br_taken = rs1_data >= rs2_data;
            default:             br_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_jalr) begin
            // lsb of jalr target is dropped
            target = (rs1_data + i_imm) & ~32'd1;
        end else if (is_jal) begin
            target = if_id_state.inst_pc + j_imm;
        end else begin
            target = if_id_state.inst_pc + b_imm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            jump_inst_q <= 1'b0;
            do_jump_q   <= 1'b0;
        end else if (if_id_state.valid) begin
            // any new instruction retires the previous report
            jump_inst_q <= is_branch | is_jal | is_jalr;
            do_jump_q   <= (is_branch & br_taken) | is_jal | is_jalr;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_state.valid) begin
            dest_q <= target;
            tag_q  <= if_id_state.inst_counter;
        end
    end

    assign jump.report.jump_inst    = jump_inst_q;
    assign jump.report.do_jump      = do_jump_q;
    assign jump.report.dest_addr    = dest_q;
    assign jump.report.inst_counter = tag_q;

endmodule

`default_nettype wire

// File: fetch_top.sv
`default_nettype none

module fetch_top (
    input  logic              clk,
    input  logic              rst,
    input  common_pkg::bool   enable,
    input  common_pkg::word_t rs1_data,
    input  common_pkg::word_t rs2_data,
    output common_pkg::bool   inst_valid,
    output common_pkg::word_t inst,
    output common_pkg::addr_t inst_pc,
    output common_pkg::word_t inst_counter,
    output common_pkg::addr_t pc,
    output common_pkg::bool   ok
);

    temp_storage_pkg::if_id_t if_id_state;

    ibus_if ibus ();
    jump_if jump ();

    fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .ibus        (ibus.fetch_mp),
        .jump        (jump.fetch_mp),
        .pc          (pc),
        .if_id_state (if_id_state),
        .ok          (ok)
    );

    inst_rom u_inst_rom (
        .clk  (clk),
        .rst  (rst),
        .ibus (ibus.rom_mp)
    );

    // operands come straight from the ports
    jump_unit u_jump_unit (
        .clk         (clk),
        .rst         (rst),
        .if_id_state (if_id_state),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .jump        (jump.unit_mp)
    );

    assign inst_valid   = if_id_state.valid;
    assign inst         = if_id_state.inst;
    assign inst_pc      = if_id_state.inst_pc;
    assign inst_counter = if_id_state.inst_counter;

endmodule

`default_nettype wire

// File: tb_fetch.sv
`default_nettype none

module tb_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INST  = 60;
    localparam int TIMEOUT = 50;

    logic              clk;
    logic              rst;
    logic              enable;
    common_pkg::word_t rs1_data;
    common_pkg::word_t rs2_data;
    logic              inst_valid;
    common_pkg::word_t inst;
    common_pkg::addr_t inst_pc;
    common_pkg::word_t inst_counter;
    common_pkg::addr_t pc;
    logic              ok;

    common_pkg::word_t prog [common_pkg::ROM_WORDS];
    int                prog_len;
    logic [31:0]       rng;
    int                errors;
    int                timeouts;

    fetch_top UUT (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .inst_counter (inst_counter),
        .pc           (pc),
        .ok           (ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_control(input common_pkg::word_t w);
        return (w[6:0] == common_pkg::OP_BRANCH) || (w[6:0] == common_pkg::OP_JAL)
            || (w[6:0] == common_pkg::OP_JALR);
    endfunction

    function automatic common_pkg::word_t rom_word(input common_pkg::addr_t a);
        return prog[a[9:2]];
    endfunction

    // expected pc after instruction w at pc_in with the two operands
    function automatic common_pkg::addr_t next_pc(
        input common_pkg::addr_t pc_in,
        input common_pkg::word_t w,
        input common_pkg::word_t a,
        input common_pkg::word_t b
    );
        common_pkg::word_t imm_b;
        common_pkg::word_t imm_j;
        common_pkg::word_t imm_i;
        logic              taken;
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_i = {{20{w[31]}}, w[31:20]};
        case (w[14:12])
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            3'b111:  taken = (a >= b);
            default: taken = 1'b0;
        endcase
        if (w[6:0] == common_pkg::OP_JAL) begin
            return pc_in + imm_j;
        end else if (w[6:0] == common_pkg::OP_JALR) begin
            return (a + imm_i) & ~32'd1;
        end else if (w[6:0] == common_pkg::OP_BRANCH && taken) begin
            return pc_in + imm_b;
        end
        return pc_in + 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // sampled on falling edges since each valid lasts a single cycle
    task automatic wait_inst(output logic found);
        found = 1'b0;
        for (int c = 0; c < TIMEOUT && !found; c++) begin
            @(negedge clk);
            found = inst_valid;
        end
    endtask

    // looks ahead to the next control instruction so a jalr lands inside the program
    task automatic choose_operands(input common_pkg::addr_t from_pc);
        common_pkg::addr_t a;
        common_pkg::word_t w;
        common_pkg::addr_t target;
        a = from_pc;
        w = rom_word(a);
        for (int k = 0; k < 64 && !is_control(w); k++) begin
            a = a + 32'd4;
            w = rom_word(a);
        end
        rng = xorshift32(rng);
        rs1_data = rng;
        rng = xorshift32(rng);
        // equal operands now and then so beq and bge see ties
        rs2_data = (rng[1:0] == 2'b00) ? rs1_data : rng;
        if (w[6:0] == common_pkg::OP_JALR) begin
            target = common_pkg::PCINIT + 32'd4 * (rng[15:2] % prog_len);
            // base is odd half the time and the target lsb still clears
            rs1_data = target - {{20{w[31]}}, w[31:20]} + rng[16];
        end
    endtask

    initial begin
        logic              found;
        common_pkg::addr_t exp_pc;
        common_pkg::word_t exp_inst;
        int                gap;
        errors   = 0;
        timeouts = 0;
        rng      = 32'd26306;
        rst      = 1'b1;
        enable   = 1'b1;
        rs1_data = '0;
        rs2_data = '0;
        prog_len = 0;
        $readmemh("program.hex", prog);
        for (int k = 0; k < common_pkg::ROM_WORDS; k++) begin
            if (!$isunknown(prog[k])) begin
                prog_len++;
            end
        end
        exp_pc = common_pkg::PCINIT;
        choose_operands(exp_pc);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // reset bubble still on the outputs here
        @(negedge clk);

        for (int i = 1; i <= N_INST; i++) begin
            wait_inst(found);
            if (!found) begin
                timeouts++;
                $display("timeout: instruction %0d did not arrive within %0d cycles",
                         i, TIMEOUT);
                break;
            end
            exp_inst = rom_word(exp_pc);
            check_value("inst_pc", inst_pc, exp_pc);
            check_value("inst", inst, exp_inst);
            check_value("inst_counter", inst_counter, i);
            check_value("pc", pc, exp_pc);
            // walk follows the model rather than the returned pc
            exp_pc = next_pc(exp_pc, exp_inst, rs1_data, rs2_data);

            @(posedge clk);
            #1;
            if (is_control(exp_inst)) begin
                choose_operands(exp_pc);
            end
            if (!enable) begin
                // outstanding fetch has landed so nothing new may issue
                rng = xorshift32(rng);
                gap = 2 + rng[2:0];
                for (int g = 0; g < gap; g++) begin
                    @(negedge clk);
                    check_value("inst_valid", inst_valid, 1'b0);
                    check_value("ok", ok, 1'b1);
                end
                @(posedge clk);
                #1;
                enable = 1'b1;
            end else if (!is_control(exp_inst)) begin
                // next request already went out on this edge
                rng = xorshift32(rng);
                if (rng[1:0] == 2'b00) begin
                    enable = 1'b0;
                end
            end
        end

        $display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: program.hex
// instruction rom image, line n holds the word at 0x80000000 + 4*n
// one 32-bit rv32i instruction word per line, hex
00100093
00200113
00208463
00300193
00209463
00400213
0020C463
00500293
0020D463
00600313
0020E463
00700393
0020F463
00800413
008000EF
00900493
00A00513
00D00693
00208733
00128067
00B00593
00F00793
FE20C4E3
00C00613
40110833
F9DFF06F

// File: project.f
common_pkg.sv
temp_storage_pkg.sv
ibus_if.sv
jump_if.sv
fetch.sv
inst_rom.sv
jump_unit.sv
fetch_top.sv
tb_fetch.sv

// File: Bender.yml
package:
  name: rv_fetch

sources:
  - common_pkg.sv
  - temp_storage_pkg.sv
  - ibus_if.sv
  - jump_if.sv
  - fetch.sv
  - inst_rom.sv
  - jump_unit.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch.sv
